// ==== buffer_link_table.sv ====
module buffer_link_table import packet_gather_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,

    input  logic      link_wr,
    input  ptr_t      link_wr_ptr,
    input  ptr_t      link_wr_nxt_ptr,
    input  logic      link_wr_eof,
    input  buf_size_t link_wr_size,
    input  logic      link_wr_err,
    input  meta_t     link_wr_meta,

    input  logic      gather_req,
    input  ptr_t      gather_ptr,
    output logic      gather_vld,
    output ptr_t      gather_nxt_ptr,
    output logic      gather_eof,
    output buf_size_t gather_size,
    output meta_t     gather_meta,
    output logic      gather_err
);

    localparam int NUM_BUFFERS = 2 ** $bits(ptr_t);

    typedef struct packed {
        ptr_t      nxt_ptr;
        logic      eof;
        buf_size_t size;
        meta_t     meta;
        logic      err;
    } link_rec_t;

    link_rec_t table_q [NUM_BUFFERS];
    link_rec_t wr_rec;
    link_rec_t rec_q;

    assign wr_rec = '{nxt_ptr: link_wr_nxt_ptr, eof: link_wr_eof, size: link_wr_size,
                      meta: link_wr_meta, err: link_wr_err};

    always_ff @(posedge clk) begin
        if (link_wr) begin
            table_q[link_wr_ptr] <= wr_rec;
        end
    end

    // lookup, newest write wins on a collision.
    always_ff @(posedge clk) begin
        if (gather_req) begin
            rec_q <= (link_wr && link_wr_ptr == gather_ptr) ? wr_rec : table_q[gather_ptr];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            gather_vld <= 1'b0;
        end else begin
            gather_vld <= gather_req;
        end
    end

    assign gather_nxt_ptr = rec_q.nxt_ptr;
    assign gather_eof     = rec_q.eof;
    assign gather_size    = rec_q.size;
    assign gather_meta    = rec_q.meta;
    assign gather_err     = rec_q.err;

endmodule : buffer_link_table

// ==== buffer_mem.sv ====
`include "packet_gather_config.svh"

module buffer_mem import packet_gather_pkg::*; (
    input  logic  clk,
    input  logic  arst_n,

    input  logic  mem_wr,
    input  addr_t mem_wr_addr,
    input  data_t mem_wr_data,

    input  logic  mem_rd_req,
    input  addr_t mem_rd_addr,
    output logic  mem_rd_ack,
    output data_t mem_rd_data
);

    localparam int LAT       = `PG_MEM_RD_LATENCY;
    localparam int NUM_WORDS = 2 ** $bits(addr_t);

    data_t          mem [NUM_WORDS];
    data_t          data_pipe [LAT];
    logic [LAT-1:0] ack_pipe;

    ////////////////////////////////////////
    // storage
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (mem_wr) begin
            mem[mem_wr_addr] <= mem_wr_data;
        end
    end

    ////////////////////////////////////////
    // read pipeline
    ////////////////////////////////////////

    // one new read may enter every cycle.
    always_ff @(posedge clk) begin
        data_pipe[0] <= mem[mem_rd_addr];
        for (int i = 1; i < LAT; i++) begin
            data_pipe[i] <= data_pipe[i-1];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ack_pipe <= '0;
        end else begin
            ack_pipe[0] <= mem_rd_req;
            for (int i = 1; i < LAT; i++) begin
                ack_pipe[i] <= ack_pipe[i-1];
            end
        end
    end

    assign mem_rd_ack  = ack_pipe[LAT-1];
    assign mem_rd_data = data_pipe[LAT-1];

endmodule : buffer_mem

// ==== packet_gather.f ====
+incdir+.
packet_gather_pkg.sv
sync_fifo.sv
buffer_link_table.sv
buffer_mem.sv
packet_gather.sv
packet_gather_top.sv
tb_packet_gather.sv

// ==== packet_gather.sv ====
`include "packet_gather_config.svh"

module packet_gather import packet_gather_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,

    input  logic        desc_vld,
    output logic        desc_rdy,
    input  desc_t       desc,

    output logic        gather_req,
    output ptr_t        gather_ptr,
    input  logic        gather_vld,
    input  ptr_t        gather_nxt_ptr,
    input  logic        gather_eof,
    input  buf_size_t   gather_size,
    input  meta_t       gather_meta,
    input  logic        gather_err,

    output logic        mem_rd_req,
    output addr_t       mem_rd_addr,
    input  logic        mem_rd_ack,
    input  data_t       mem_rd_data,

    output logic        packet_vld,
    input  logic        packet_rdy,
    output logic        packet_eop,
    output data_t       packet_data,
    output mty_t        packet_mty,
    output logic        packet_err,
    output meta_t       packet_meta,

    output logic        packet_event_evt,
    output pkt_size_t   packet_event_size,
    output evt_status_e packet_event_status
);

    localparam int LAT        = `PG_MEM_RD_LATENCY;
    localparam int RD_DEPTH   = `PG_RD_FIFO_DEPTH;
    localparam int IDX_WID    = $bits(addr_t) - $bits(ptr_t);
    localparam int WORD_SHIFT = $clog2(`PG_DATA_BYTES);

    typedef logic [IDX_WID-1:0] idx_t;
    typedef logic [$clog2(RD_DEPTH+1)-1:0] cnt_t;

    logic      busy;
    logic      walk_pass;    // 0 sums the chain, 1 feeds the reader.
    logic      look_pend;
    logic      look_done;
    desc_t     desc_q;
    ptr_t      look_ptr;
    pkt_size_t total;
    logic      err_acc;

    logic      rec_vld;
    ptr_t      rec_ptr;
    idx_t      rec_last;
    mty_t      rec_mty;
    logic      rec_eof;
    logic      rec_load;

    logic      cur_act;
    ptr_t      cur_ptr;
    idx_t      cur_idx;
    idx_t      cur_last;
    mty_t      cur_mty;
    logic      cur_eof;
    logic      rd_go;
    logic      rd_last;

    cnt_t      inflight;
    cnt_t      rd_count;
    logic      tag_eop [LAT];
    mty_t      tag_mty [LAT];
    beat_t     beat_in;
    beat_t     beat_out;
    logic      rd_empty;
    logic      eop_taken;

    ////////////////////////////////////////
    // chain walk
    ////////////////////////////////////////

    assign desc_rdy   = !busy;
    assign gather_req = busy && !look_pend && !look_done && (!walk_pass || !rec_vld);
    assign gather_ptr = look_ptr;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy      <= 1'b0;
            walk_pass <= 1'b0;
            look_pend <= 1'b0;
            look_done <= 1'b0;
            rec_vld   <= 1'b0;
        end else begin
            if (desc_vld && desc_rdy) begin
                busy      <= 1'b1;
                walk_pass <= 1'b0;
                look_done <= 1'b0;
            end else if (eop_taken) begin
                busy <= 1'b0;
            end
            if (gather_req) begin
                look_pend <= 1'b1;
            end else if (gather_vld) begin
                look_pend <= 1'b0;
            end
            if (gather_vld && gather_eof) begin
                if (walk_pass) begin
                    look_done <= 1'b1;
                end else begin
                    walk_pass <= 1'b1;    // rewalk, now for reads.
                end
            end
            if (gather_vld && walk_pass) begin
                rec_vld <= 1'b1;
            end else if (rec_load) begin
                rec_vld <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (desc_vld && desc_rdy) begin
            desc_q   <= desc;
            look_ptr <= desc.addr;
            total    <= '0;
            err_acc  <= desc.err;
        end
        if (gather_vld) begin
            if (!walk_pass) begin
                total    <= total + gather_size;
                err_acc  <= err_acc | gather_err;
                look_ptr <= gather_eof ? desc_q.addr : gather_nxt_ptr;
            end else begin
                look_ptr <= gather_nxt_ptr;
                rec_ptr  <= look_ptr;
                rec_eof  <= gather_eof;
                rec_last <= idx_t'((gather_size - 1'b1) >> WORD_SHIFT);
                rec_mty  <= mty_t'(`PG_DATA_BYTES - gather_size);
            end
        end
    end

    ////////////////////////////////////////
    // credited word reads
    ////////////////////////////////////////

    assign rd_go       = cur_act && ((rd_count + inflight) < RD_DEPTH);
    assign rd_last     = (cur_idx == cur_last);
    assign rec_load    = rec_vld && (!cur_act || (rd_go && rd_last));
    assign mem_rd_req  = rd_go;
    assign mem_rd_addr = {cur_ptr, cur_idx};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cur_act  <= 1'b0;
            inflight <= '0;
        end else begin
            if (rec_load) begin
                cur_act <= 1'b1;
            end else if (rd_go && rd_last) begin
                cur_act <= 1'b0;
            end
            case ({rd_go, mem_rd_ack})
                2'b10:   inflight <= inflight + 1'b1;
                2'b01:   inflight <= inflight - 1'b1;
                default: inflight <= inflight;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rec_load) begin
            cur_ptr  <= rec_ptr;
            cur_idx  <= '0;
            cur_last <= rec_last;
            cur_mty  <= rec_mty;
            cur_eof  <= rec_eof;
        end else if (rd_go) begin
            cur_idx <= cur_idx + 1'b1;
        end
    end

    // tags ride alongside the memory pipeline.
    always_ff @(posedge clk) begin
        tag_eop[0] <= cur_eof && rd_last;
        tag_mty[0] <= (cur_eof && rd_last) ? cur_mty : '0;
        for (int i = 1; i < LAT; i++) begin
            tag_eop[i] <= tag_eop[i-1];
            tag_mty[i] <= tag_mty[i-1];
        end
    end

    ////////////////////////////////////////
    // beat output and completion
    ////////////////////////////////////////

    assign beat_in = '{data: mem_rd_data, eop: tag_eop[LAT-1], mty: tag_mty[LAT-1]};

    sync_fifo #(
        .payload_t ( beat_t   ),
        .DEPTH     ( RD_DEPTH )
    ) rd_fifo0 (
        .clk     ( clk        ),
        .arst_n  ( arst_n     ),
        .wr      ( mem_rd_ack ),
        .wr_data ( beat_in    ),
        .full    (            ),
        .rd      ( packet_rdy ),
        .rd_data ( beat_out   ),
        .empty   ( rd_empty   ),
        .count   ( rd_count   )
    );

    assign packet_vld  = !rd_empty;
    assign packet_data = beat_out.data;
    assign packet_eop  = beat_out.eop;
    assign packet_mty  = beat_out.mty;
    assign packet_err  = err_acc;    // known before the first read.
    assign packet_meta = desc_q.meta;
    assign eop_taken   = packet_vld && packet_rdy && packet_eop;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            packet_event_evt <= 1'b0;
        end else begin
            packet_event_evt <= eop_taken;
        end
    end

    always_ff @(posedge clk) begin
        if (eop_taken) begin
            packet_event_size <= total;
            if (err_acc) begin
                packet_event_status <= EVT_ERR;
            end else if (total != desc_q.size) begin
                packet_event_status <= EVT_SIZE_MISMATCH;
            end else begin
                packet_event_status <= EVT_OK;
            end
        end
    end

endmodule : packet_gather

// ==== packet_gather_config.svh ====
`ifndef PACKET_GATHER_CONFIG_SVH
`define PACKET_GATHER_CONFIG_SVH

// data path.
`define PG_DATA_BYTES 4

// buffers.
`define PG_BUFFER_SIZE 64
`define PG_PTR_WID 4

// packet attributes.
`define PG_META_WID 5
`define PG_MAX_PKT_SIZE 1024

// queues.
`define PG_DESC_DEPTH 4
`define PG_RD_FIFO_DEPTH 8

// buffer memory read pipeline.
`define PG_MEM_RD_LATENCY 3

`endif

// ==== packet_gather_pkg.sv ====
`include "packet_gather_config.svh"

package packet_gather_pkg;

    localparam int WORD_IDX_WID = $clog2(`PG_BUFFER_SIZE / `PG_DATA_BYTES);

    typedef logic [`PG_PTR_WID-1:0] ptr_t;
    typedef logic [`PG_PTR_WID+WORD_IDX_WID-1:0] addr_t;    // {ptr, word index}.
    typedef logic [`PG_DATA_BYTES*8-1:0] data_t;
    typedef logic [$clog2(`PG_DATA_BYTES)-1:0] mty_t;
    typedef logic [`PG_META_WID-1:0] meta_t;
    typedef logic [$clog2(`PG_BUFFER_SIZE+1)-1:0] buf_size_t;
    typedef logic [$clog2(`PG_MAX_PKT_SIZE+1)-1:0] pkt_size_t;

    typedef struct packed {
        ptr_t      addr;    // first buffer.
        pkt_size_t size;
        logic      err;
        meta_t     meta;
    } desc_t;

    typedef struct packed {
        data_t data;
        logic  eop;
        mty_t  mty;
    } beat_t;

    typedef enum logic [2:0] {
        EVT_OK            = 3'd0,
        EVT_ERR           = 3'd1,
        EVT_SIZE_MISMATCH = 3'd2
    } evt_status_e;

endpackage : packet_gather_pkg

// ==== packet_gather_top.sv ====
`include "packet_gather_config.svh"

module packet_gather_top import packet_gather_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,

    input  logic        descriptor_vld,
    output logic        descriptor_rdy,
    input  ptr_t        descriptor_addr,
    input  pkt_size_t   descriptor_size,
    input  logic        descriptor_err,
    input  meta_t       descriptor_meta,

    input  logic        link_wr,
    input  ptr_t        link_wr_ptr,
    input  ptr_t        link_wr_nxt_ptr,
    input  logic        link_wr_eof,
    input  buf_size_t   link_wr_size,
    input  logic        link_wr_err,
    input  meta_t       link_wr_meta,

    input  logic        mem_wr,
    input  addr_t       mem_wr_addr,
    input  data_t       mem_wr_data,

    output logic        packet_vld,
    input  logic        packet_rdy,
    output logic        packet_eop,
    output data_t       packet_data,
    output mty_t        packet_mty,
    output logic        packet_err,
    output meta_t       packet_meta,

    output logic        packet_event_evt,
    output pkt_size_t   packet_event_size,
    output evt_status_e packet_event_status
);

    logic      desc_full;
    logic      desc_empty;
    logic      desc_vld;
    logic      desc_rdy;
    desc_t     desc;

    logic      gather_req;
    ptr_t      gather_ptr;
    logic      gather_vld;
    ptr_t      gather_nxt_ptr;
    logic      gather_eof;
    buf_size_t gather_size;
    meta_t     gather_meta;
    logic      gather_err;

    logic      mem_rd_req;
    addr_t     mem_rd_addr;
    logic      mem_rd_ack;
    data_t     mem_rd_data;

    assign descriptor_rdy = !desc_full;
    assign desc_vld       = !desc_empty;

    sync_fifo #(
        .payload_t ( desc_t         ),
        .DEPTH     ( `PG_DESC_DEPTH )
    ) desc_fifo0 (
        .clk     ( clk            ),
        .arst_n  ( arst_n         ),
        .wr      ( descriptor_vld ),
        .wr_data ( {descriptor_addr, descriptor_size, descriptor_err, descriptor_meta} ),
        .full    ( desc_full      ),
        .rd      ( desc_rdy       ),
        .rd_data ( desc           ),
        .empty   ( desc_empty     ),
        .count   (                )
    );

    packet_gather gather0 (.*);

    buffer_link_table link_table0 (.*);

    buffer_mem mem0 (.*);

endmodule : packet_gather_top

// ==== run_sim.sh ====
#!/bin/sh
# Builds the packet gather testbench with Verilator and runs it.
# Exit status is nonzero unless the log holds the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module tb_packet_gather \
    -f packet_gather.f -o sim_packet_gather > build.log 2>&1 &&
    ./obj_dir/sim_packet_gather > sim.log 2>&1 &&
    grep -q "^Simulation finished: PASS$" sim.log &&
    echo "run passed, see sim.log" ||
    { echo "run failed, see build.log and sim.log"; exit 1; }

// ==== sync_fifo.sv ====
module sync_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 4
) (
    input  logic                         clk,
    input  logic                         arst_n,

    input  logic                         wr,
    input  payload_t                     wr_data,
    output logic                         full,

    input  logic                         rd,
    output payload_t                     rd_data,
    output logic                         empty,

    output logic [$clog2(DEPTH+1)-1:0]   count
);

    localparam int PTR_WID = $clog2(DEPTH);

    payload_t           mem [DEPTH];
    logic [PTR_WID-1:0] wr_ptr;
    logic [PTR_WID-1:0] rd_ptr;
    logic               wr_en;
    logic               rd_en;
    logic [$clog2(DEPTH+1)-1:0] count_nxt;

    assign wr_en   = wr && !full;
    assign rd_en   = rd && !empty;
    assign empty   = (count == '0);
    assign rd_data = mem[rd_ptr];    // head is always visible.

    always_comb begin
        count_nxt = count;
        if (wr_en && !rd_en) begin
            count_nxt = count + 1'b1;
        end else if (rd_en && !wr_en) begin
            count_nxt = count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            full   <= 1'b1;    // refuse writes through reset.
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == PTR_WID'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == PTR_WID'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count_nxt;
            full  <= (count_nxt == $bits(count)'(DEPTH));
        end
    end

endmodule : sync_fifo

// ==== tb_packet_gather.sv ====
`include "packet_gather_config.svh"

module tb_packet_gather import packet_gather_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int WAIT_LIMIT = 4000;
    localparam int NUM_BUF    = 2 ** $bits(ptr_t);
    localparam int WORDS      = `PG_BUFFER_SIZE / `PG_DATA_BYTES;
    localparam int IDX_W      = $clog2(WORDS);
    localparam int BEAT_W     = $bits(data_t) + $bits(mty_t) + $bits(meta_t) + 2;
    localparam int EVT_W      = $bits(pkt_size_t) + $bits(evt_status_e);

    logic        clk = 1'b0;
    logic        arst_n;
    logic        descriptor_vld;
    logic        descriptor_rdy;
    ptr_t        descriptor_addr;
    pkt_size_t   descriptor_size;
    logic        descriptor_err;
    meta_t       descriptor_meta;
    logic        link_wr;
    ptr_t        link_wr_ptr;
    ptr_t        link_wr_nxt_ptr;
    logic        link_wr_eof;
    buf_size_t   link_wr_size;
    logic        link_wr_err;
    meta_t       link_wr_meta;
    logic        mem_wr;
    addr_t       mem_wr_addr;
    data_t       mem_wr_data;
    logic        packet_vld;
    logic        packet_rdy = 1'b0;
    logic        packet_eop;
    data_t       packet_data;
    mty_t        packet_mty;
    logic        packet_err;
    meta_t       packet_meta;
    logic        packet_event_evt;
    pkt_size_t   packet_event_size;
    evt_status_e packet_event_status;

    // shadow of what was loaded into the DUT.
    ptr_t        sh_nxt [NUM_BUF];
    logic        sh_eof [NUM_BUF];
    buf_size_t   sh_size [NUM_BUF];
    logic        sh_err [NUM_BUF];
    data_t       sh_mem [NUM_BUF*WORDS];

    logic [BEAT_W-1:0] exp_beat [1024];
    logic [EVT_W-1:0]  exp_evt [256];
    logic [BEAT_W-1:0] beat_now;
    int          exp_wr = 0;
    int          exp_rd = 0;
    int          evt_wr = 0;
    int          evt_rd = 0;

    int          seed = 32'he3a0_17f3;
    logic        rdy_random = 1'b0;
    logic        rdy_seen_low = 1'b0;
    int          errors = 0;
    int          base_errors = 0;
    int          passed = 0;
    int          failed = 0;

    packet_gather_top dut0 (.*);

    initial begin
        forever #2 clk = ~clk;
    end

    assign beat_now = {packet_data, packet_eop, packet_mty, packet_err, packet_meta};

    always @(posedge clk) begin : rdy_drive
        int rnd;
        if (rdy_random) begin
            rnd = $random(seed);
            packet_rdy <= rnd[0];
        end else begin
            packet_rdy <= 1'b1;
        end
    end

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            exp_rd <= 0;
            evt_rd <= 0;
        end else begin
            if (packet_vld && packet_rdy) exp_rd <= exp_rd + 1;    // beat consumed.
            if (packet_event_evt) evt_rd <= evt_rd + 1;
        end
    end

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////

    beat_match: assert property (@(posedge clk) disable iff (!arst_n)
        (packet_vld && packet_rdy) |-> (exp_rd != exp_wr && beat_now == exp_beat[exp_rd]))
        else report_fail("beat differs from the model or was not expected");

    beat_hold: assert property (@(posedge clk) disable iff (!arst_n)
        (packet_vld && !packet_rdy) |=> (packet_vld && $stable(beat_now)))
        else report_fail("beat changed while stalled");

    event_match: assert property (@(posedge clk) disable iff (!arst_n)
        packet_event_evt |->
            (evt_rd != evt_wr && {packet_event_size, packet_event_status} == exp_evt[evt_rd]))
        else report_fail("event size or status differs from the model");

    event_after_eop: assert property (@(posedge clk) disable iff (!arst_n)
        (packet_vld && packet_rdy && packet_eop) |=> packet_event_evt)
        else report_fail("no event after the eop beat");

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////

    task automatic report_fail(input string msg);
        $display("FAIL at %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic end_run();
        $display("tests passed %0d, tests failed %0d, failed checks %0d", passed, failed, errors);
        if (failed == 0 && errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    endtask

    task automatic abort_on_timeout(input string what);
        $display("timed out at %0t while waiting for %s", $time, what);
        failed++;
        end_run();
    endtask

    task automatic start_test();
        base_errors = errors;
    endtask

    task automatic finish_test(input string name);
        if (errors == base_errors) begin
            passed++;
            $display("test %s: ok", name);
        end else begin
            failed++;
            $display("test %s: %0d check(s) failed", name, errors - base_errors);
        end
    endtask

    // fills a whole buffer with random words, then writes its link record.
    task automatic load_buffer(input ptr_t p, input ptr_t nxt, input logic eof,
                               input buf_size_t size, input logic err);
        data_t word;
        for (int w = 0; w < WORDS; w++) begin
            word = $random(seed);
            mem_wr      <= 1'b1;
            mem_wr_addr <= addr_t'({p, IDX_W'(w)});
            mem_wr_data <= word;
            sh_mem[{p, IDX_W'(w)}] = word;
            @(posedge clk);
        end
        mem_wr          <= 1'b0;
        link_wr         <= 1'b1;
        link_wr_ptr     <= p;
        link_wr_nxt_ptr <= nxt;
        link_wr_eof     <= eof;
        link_wr_size    <= size;
        link_wr_err     <= err;
        link_wr_meta    <= meta_t'($random(seed));
        sh_nxt[p]  = nxt;
        sh_eof[p]  = eof;
        sh_size[p] = size;
        sh_err[p]  = err;
        @(posedge clk);
        link_wr <= 1'b0;
    endtask

    // expected beats and event of one packet.
    task automatic model_packet(input ptr_t addr, input pkt_size_t size, input logic err,
                                input meta_t meta);
        ptr_t        chain [NUM_BUF];
        ptr_t        p;
        int          len;
        int          total;
        int          words;
        logic        any_err;
        logic        eop;
        mty_t        mty;
        evt_status_e status;
        p       = addr;
        len     = 0;
        total   = 0;
        any_err = err;
        for (int n = 0; n < NUM_BUF; n++) begin
            chain[len] = p;
            len++;
            total += int'(sh_size[p]);
            any_err |= sh_err[p];
            if (sh_eof[p]) break;
            p = sh_nxt[p];
        end
        mty = mty_t'((`PG_DATA_BYTES - total % `PG_DATA_BYTES) % `PG_DATA_BYTES);
        for (int i = 0; i < len; i++) begin
            words = (int'(sh_size[chain[i]]) + `PG_DATA_BYTES - 1) / `PG_DATA_BYTES;
            for (int w = 0; w < words; w++) begin
                eop = (i == len - 1) && (w == words - 1);
                exp_beat[exp_wr] = {sh_mem[{chain[i], IDX_W'(w)}], eop,
                                    eop ? mty : mty_t'(0), any_err, meta};
                exp_wr++;
            end
        end
        if (any_err) begin
            status = EVT_ERR;    // wins over a size mismatch.
        end else if (total != int'(size)) begin
            status = EVT_SIZE_MISMATCH;
        end else begin
            status = EVT_OK;
        end
        exp_evt[evt_wr] = {pkt_size_t'(total), status};
        evt_wr++;
    endtask

    // leaves descriptor_vld high so the next call runs back to back.
    task automatic send_desc(input ptr_t addr, input pkt_size_t size, input logic err,
                             input meta_t meta);
        int   waited;
        logic taken;
        model_packet(addr, size, err, meta);
        descriptor_vld  <= 1'b1;
        descriptor_addr <= addr;
        descriptor_size <= size;
        descriptor_err  <= err;
        descriptor_meta <= meta;
        waited = 0;
        taken  = 1'b0;
        while (!taken && waited < WAIT_LIMIT) begin
            @(posedge clk);
            waited++;
            taken = descriptor_rdy;
            if (!taken) rdy_seen_low = 1'b1;
        end
        if (!taken) abort_on_timeout("descriptor_rdy");
    endtask

    task automatic stop_desc();
        descriptor_vld <= 1'b0;
    endtask

    task automatic wait_drain(input string what);
        int waited;
        waited = 0;
        while ((exp_rd != exp_wr || evt_rd != evt_wr) && waited < WAIT_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (exp_rd != exp_wr || evt_rd != evt_wr) begin
            abort_on_timeout(what);
        end else begin
            repeat (2) @(posedge clk);
        end
    endtask

    ////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////

    initial begin : stimulus
        pkt_size_t sizes [6];
        buf_size_t sz;
        int        rnd;
        arst_n          = 1'b0;
        descriptor_vld  = 1'b0;
        descriptor_addr = '0;
        descriptor_size = '0;
        descriptor_err  = 1'b0;
        descriptor_meta = '0;
        link_wr         = 1'b0;
        link_wr_ptr     = '0;
        link_wr_nxt_ptr = '0;
        link_wr_eof     = 1'b0;
        link_wr_size    = '0;
        link_wr_err     = 1'b0;
        link_wr_meta    = '0;
        mem_wr          = 1'b0;
        mem_wr_addr     = '0;
        mem_wr_data     = '0;
        repeat (5) @(posedge clk);
        start_test();
        assert (!packet_vld && !packet_event_evt && !descriptor_rdy)
            else report_fail("outputs not idle in reset");
        arst_n <= 1'b1;
        @(posedge clk);
        load_buffer(0, 0, 1, 13, 0);
        send_desc(0, 13, 0, 5'h15);
        stop_desc();
        wait_drain("single buffer packet");
        finish_test("1 single buffer");

        start_test();
        load_buffer(1, 2, 0, 64, 0);
        load_buffer(2, 3, 0, 64, 0);
        load_buffer(3, 0, 1, 22, 0);
        send_desc(1, 150, 0, 5'h0a);
        stop_desc();
        wait_drain("three buffer chain");
        finish_test("2 three buffer chain");

        start_test();
        for (int k = 0; k < 4; k++) begin
            rnd = $random(seed);
            sz  = buf_size_t'(rnd[5:0]) + 1'b1;
            load_buffer(ptr_t'(4 + 2*k), ptr_t'(5 + 2*k), 0, 64, 0);
            load_buffer(ptr_t'(5 + 2*k), 0, 1, sz, 0);
            sizes[k] = pkt_size_t'(64 + int'(sz));
        end
        rdy_random <= 1'b1;
        for (int k = 0; k < 4; k++) begin
            send_desc(ptr_t'(4 + 2*k), sizes[k], 0, meta_t'(k + 1));
        end
        stop_desc();
        wait_drain("random back-pressure packets");
        rdy_random <= 1'b0;
        @(posedge clk);
        finish_test("3 random back-pressure");

        start_test();
        load_buffer(0, 0, 1, 20, 0);
        load_buffer(1, 2, 0, 64, 0);
        load_buffer(2, 0, 1, 40, 1);
        rdy_random <= 1'b1;
        send_desc(0, 20, 1, 5'h03);
        send_desc(1, 99, 0, 5'h1c);    // size is off too.
        stop_desc();
        wait_drain("error packets");
        rdy_random <= 1'b0;
        @(posedge clk);
        finish_test("4 error flags");

        start_test();
        load_buffer(3, 4, 0, 64, 0);
        load_buffer(4, 0, 1, 10, 0);
        send_desc(3, 80, 0, 5'h11);
        stop_desc();
        wait_drain("size mismatch packet");
        finish_test("5 size mismatch");

        start_test();
        for (int k = 0; k < 6; k++) begin
            rnd = $random(seed);
            sz  = buf_size_t'(rnd[5:0]) + 1'b1;
            load_buffer(ptr_t'(k), 0, 1, sz, 0);
            sizes[k] = pkt_size_t'(sz);
        end
        rdy_seen_low = 1'b0;
        for (int k = 0; k < 6; k++) begin
            send_desc(ptr_t'(k), sizes[k], 0, meta_t'(k + 8));
        end
        stop_desc();
        assert (rdy_seen_low) else report_fail("descriptor_rdy stayed high with the queue full");
        wait_drain("six queued packets");
        finish_test("6 descriptor queue full");

        end_run();
    end

endmodule : tb_packet_gather
